/* common/st_defs.svh */
`ifndef ST_DEFS_SVH
`define ST_DEFS_SVH

// audio widths
`define ST_SAMPLE_W 15    // signed sample from the ST sound mix
`define ST_AUDIO_W  16    // expanded output sample

// keyboard matrix
`define ST_KBD_ROWS 15

// register bus
`define ST_AXI_AW   8     // byte address bits decoded by the register block
`define ST_AXI_DW   32

// register byte offsets
`define ST_REG_CFG  8'h00
`define ST_REG_CTRL 8'h04
`define ST_REG_STAT 8'h08

// give the MCU 2 s at 32 MHz to mount a default disk image
`define ST_SD_WAIT  64000000

`endif

/* common/st_pkg.sv */
`default_nettype none

`include "st_defs.svh"

package st_pkg;

  typedef enum logic [1:0] {
    ST   = 2'd0,
    MEGA = 2'd1,  // adds the blitter
    STE  = 2'd2
  } chipset_e;

  // source of the mouse on joystick port 0
  typedef enum logic [1:0] {
    HID       = 2'd0,
    DB9_ATARI = 2'd1,
    DB9_AMIGA = 2'd2,
    NONE      = 2'd3
  } port_mouse_e;

  typedef logic [`ST_AUDIO_W-1:0] audio_t;

  typedef struct packed {
    chipset_e    chipset;
    logic        extra_mem;     // enable extra ram
    logic        mono_video;    // mono monitor attached
    logic [1:0]  volume;
    port_mouse_e port_mouse;
    logic        tos_slot;      // secondary TOS image in flash
    logic [1:0]  floppy_wprot;  // per drive write protect
    logic        hold_reset;
    logic        cold_boot;
  } sys_cfg_t;

  typedef struct packed {
    logic                  awvalid;
    logic [`ST_AXI_AW-1:0] awaddr;
    logic                  wvalid;
    logic [`ST_AXI_DW-1:0] wdata;
    logic [3:0]            wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [`ST_AXI_AW-1:0] araddr;
    logic                  rready;
  } axil_req_t;

  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  arready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  rvalid;
    logic [`ST_AXI_DW-1:0] rdata;
    logic [1:0]            rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic        ras_n;
    logic        uds_n;
    logic        lds_n;
    logic        we_n;
    logic [23:1] addr;  // word address from the chipset
  } ram_req_t;

  typedef struct packed {
    logic [1:0]  rd;       // sector read request per drive
    logic [1:0]  wr;       // sector write request per drive
    logic [31:0] lba;
    logic [7:0]  wr_byte;
  } sd_req_t;

  typedef struct packed {
    logic [3:0]  rstart;   // acsi in the upper pair
    logic [3:0]  wstart;
    logic [31:0] sector;
    logic [7:0]  wr_byte;
  } sd_cmd_t;

  typedef struct packed {
    audio_t l;
    audio_t r;
  } audio_pair_t;

endpackage

`default_nettype wire

/* source/sys_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_defs.svh"

module sys_regs import st_pkg::*; (
  input  logic       clk_32,
  input  logic       rst_n,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  input  logic [1:0] scramble,
  input  logic       sd_ready,
  input  logic       core_run,
  output sys_cfg_t   cfg
);

  localparam int CFG_W = 11;  // config bits stored in CFG

  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic [CFG_W-1:0]      cfg_q;   // 1:0 chipset, 2 mem, 3 mono, 5:4 vol, 7:6 mouse, 8 tos, 10:9 wp
  logic [1:0]            ctrl_q;  // bit 1 cold boot, bit 0 hold reset
  logic                  bvalid_q;
  logic                  rvalid_q;
  logic [`ST_AXI_DW-1:0] rdata_q;
  logic [`ST_AXI_DW-1:0] stat;
  logic                  wr_hs;
  logic                  rd_hs;

  // address and data must arrive together, one write in flight
  assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_hs = axil_req.arvalid && !rvalid_q;

  assign stat = {28'd0, core_run, sd_ready, scramble};

  // register writes with byte strobes
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q  <= '0;  // volume 0 keeps audio muted
      ctrl_q <= '0;
    end else if (wr_hs) begin
      case (axil_req.awaddr)
        `ST_REG_CFG: begin
          if (axil_req.wstrb[0])
            cfg_q[7:0] <= axil_req.wdata[7:0];
          if (axil_req.wstrb[1])
            cfg_q[CFG_W-1:8] <= axil_req.wdata[CFG_W-1:8];
        end
        `ST_REG_CTRL: begin
          if (axil_req.wstrb[0])
            ctrl_q <= axil_req.wdata[1:0];
        end
        default: ;  // STAT and holes ignore writes
      endcase
    end
  end

  // pending responses, held until the master takes them
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs)
        bvalid_q <= 1'b1;
      else if (axil_req.bready)
        bvalid_q <= 1'b0;
      if (rd_hs)
        rvalid_q <= 1'b1;
      else if (axil_req.rready)
        rvalid_q <= 1'b0;
    end
  end

  // read data captured on the address handshake
  always_ff @(posedge clk_32) begin
    if (rd_hs) begin
      case (axil_req.araddr)
        `ST_REG_CFG:  rdata_q <= `ST_AXI_DW'(cfg_q);
        `ST_REG_CTRL: rdata_q <= `ST_AXI_DW'(ctrl_q);
        `ST_REG_STAT: rdata_q <= stat;
        default:      rdata_q <= '0;  // unmapped
      endcase
    end
  end

  always_comb begin
    axil_rsp.awready = wr_hs;  // ready only in the accept cycle
    axil_rsp.wready  = wr_hs;
    axil_rsp.arready = rd_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = RESP_OKAY;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = RESP_OKAY;
  end

  // unpack the stored bits into the config bundle
  always_comb begin
    cfg.chipset      = chipset_e'(cfg_q[1:0]);
    cfg.extra_mem    = cfg_q[2];
    cfg.mono_video   = cfg_q[3];
    cfg.volume       = cfg_q[5:4];
    cfg.port_mouse   = port_mouse_e'(cfg_q[7:6]);
    cfg.tos_slot     = cfg_q[8];
    cfg.floppy_wprot = cfg_q[10:9];
    cfg.hold_reset   = ctrl_q[0];
    cfg.cold_boot    = ctrl_q[1];
  end

endmodule

`default_nettype wire

/* input/input_map.sv */
`timescale 1ns/1ps
`default_nettype none

module input_map import st_pkg::*; (
  input  sys_cfg_t   cfg,
  input  logic [5:0] db9_pins,   // raw pins, low active
  input  logic [5:0] hid_mouse,  // four directions, two buttons
  input  logic [7:0] hid_joy,    // four directions, four buttons
  output logic [5:0] joy0,
  output logic [4:0] joy1,
  output logic [5:0] db9_joy
);

  logic [5:0] db9_atari;
  logic [5:0] db9_amiga;

  // the two wirings differ only in the order of direction lines
  assign db9_atari = ~{db9_pins[5], db9_pins[0], db9_pins[2],
                       db9_pins[1], db9_pins[4], db9_pins[3]};
  assign db9_amiga = ~{db9_pins[5], db9_pins[0], db9_pins[3],
                       db9_pins[1], db9_pins[4], db9_pins[2]};

  // a db9 mouse replaces the usb one
  // mice hold lines active so they cannot be ORed together
  always_comb begin
    case (cfg.port_mouse)
      HID:       joy0 = hid_mouse;
      DB9_ATARI: joy0 = db9_atari;
      DB9_AMIGA: joy0 = db9_amiga;
      default:   joy0 = 6'd0;
    endcase
  end

  // db9 port serves as joystick only while the mouse is on usb
  assign db9_joy = (cfg.port_mouse == HID) ? db9_atari : 6'd0;

  assign joy1 = hid_joy[4:0] | db9_joy[4:0];  // joysticks are simply merged

endmodule

`default_nettype wire

/* input/kbd_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_defs.svh"

module kbd_matrix (
  input  logic [`ST_KBD_ROWS-1:0][7:0] rows,       // key state per row, low = pressed
  input  logic [`ST_KBD_ROWS-1:0]      row_sel_n,  // column strobes from the ikbd
  output logic [7:0]                   cols
);

  // several strobes may be low at once
  always_comb begin
    cols = 8'hff;  // nothing selected reads as no key
    for (int i = 0; i < `ST_KBD_ROWS; i++) begin
      if (!row_sel_n[i])
        cols = cols & rows[i];
    end
  end

endmodule

`default_nettype wire

/* memory/mem_map.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_map import st_pkg::*; (
  input  logic        clk_32,
  input  logic        rst_n,
  input  sys_cfg_t    cfg,
  input  logic [23:1] rom_addr,
  output logic [22:0] flash_addr,
  input  ram_req_t    ram_req,
  output logic [22:1] ram_addr,
  output logic        ram_cs,
  output logic [1:0]  scramble
);

  logic cold_boot_d;  // previous cold boot flag
  logic is_ste;

  assign is_ste = (cfg.chipset == STE);

  // TOS at $100000 for ST and $140000 for STE
  // tos_slot picks the secondary images above them
  assign flash_addr = {1'b0, 3'b001, cfg.tos_slot, is_ste, rom_addr[17:1]};

  // each cold boot request moves to a new scramble pattern
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      cold_boot_d <= 1'b0;
      scramble    <= 2'd0;
    end else begin
      cold_boot_d <= cfg.cold_boot;
      if (cfg.cold_boot && !cold_boot_d)
        scramble <= scramble + 2'd1;
    end
  end

  // old contents become garbage without a clear pass
  assign ram_addr = {ram_req.addr[22:5], ram_req.addr[4:3] ^ scramble, ram_req.addr[2:1]};

  assign ram_cs = !ram_req.ras_n && !ram_req.addr[23];  // only 8 MB fitted

endmodule

`default_nettype wire

/* source/audio_volume.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_defs.svh"

module audio_volume import st_pkg::*; (
  input  logic                    clk_32,
  input  logic                    rst_n,
  input  logic [1:0]              volume,
  input  logic [`ST_SAMPLE_W-1:0] sample,  // signed
  output audio_t                  out
);

  logic signed [`ST_AUDIO_W-1:0] wide;
  audio_t                        scaled;

  assign wide = `ST_AUDIO_W'($signed(sample));  // sign extend

  // volume steps by signed division
  always_comb begin
    case (volume)
      2'd0:    scaled = '0;         // muted
      2'd1:    scaled = wide >>> 2;
      2'd2:    scaled = wide >>> 1;
      default: scaled = wide;       // full scale
    endcase
  end

  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n)
      out <= '0;
    else
      out <= scaled;
  end

endmodule

`default_nettype wire

/* source/boot_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_defs.svh"

module boot_ctrl import st_pkg::*; #(
  parameter int unsigned WAIT_CYCLES = `ST_SD_WAIT
) (
  input  logic        clk_32,
  input  logic        rst_n,
  input  sys_cfg_t    cfg,
  input  logic        reset_button,
  input  logic        ram_ready,
  input  logic        flash_ready,
  input  logic [31:0] img_size,
  output logic        sd_ready,
  output logic        core_run
);

  localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

  logic [CNT_W-1:0] wait_cnt;

  // a nonzero image size means the card is up and an image is mounted
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size != 32'd0)
        sd_ready <= 1'b1;
      if (wait_cnt == CNT_W'(WAIT_CYCLES))
        sd_ready <= 1'b1;  // give up waiting
      else
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // ST leaves reset only when memories and sd are usable
  assign core_run = !cfg.hold_reset && !reset_button && ram_ready && flash_ready && sd_ready;

endmodule

`default_nettype wire

/* source/sd_req_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_req_arb import st_pkg::*; (
  input  logic    clk_32,
  input  logic    rst_n,
  input  sd_req_t fdc,
  input  sd_req_t acsi,
  output sd_cmd_t cmd
);

  logic acsi_own;  // acsi was the last requester
  logic acsi_any;
  logic fdc_any;
  logic sel_acsi;

  assign acsi_any = (|acsi.rd) || (|acsi.wr);
  assign fdc_any  = (|fdc.rd) || (|fdc.wr);

  // ownership sticks after the request drops
  // data bytes flow long after the start pulse
  always_ff @(posedge clk_32 or negedge rst_n) begin
    if (!rst_n) begin
      acsi_own <= 1'b0;
    end else begin
      if (acsi_any)
        acsi_own <= 1'b1;
      if (fdc_any)
        acsi_own <= 1'b0;  // floppy wins a tie
    end
  end

  assign sel_acsi = acsi_any || acsi_own;

  always_comb begin
    cmd.rstart  = {acsi.rd, fdc.rd};
    cmd.wstart  = {acsi.wr, fdc.wr};
    cmd.sector  = sel_acsi ? acsi.lba : fdc.lba;
    cmd.wr_byte = sel_acsi ? acsi.wr_byte : fdc.wr_byte;
  end

endmodule

`default_nettype wire

/* source/st_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_defs.svh"

module st_glue_top import st_pkg::*; #(
  parameter int unsigned WAIT_CYCLES = `ST_SD_WAIT
) (
  input  logic                           clk_32,
  input  logic                           rst_n,
  input  axil_req_t                      axil_req,      // register bus from the MCU
  output axil_rsp_t                      axil_rsp,
  input  logic                           reset_button,
  input  logic                           ram_ready,
  input  logic                           flash_ready,
  input  logic [31:0]                    img_size,
  input  logic [5:0]                     db9_pins,
  input  logic [5:0]                     hid_mouse,
  input  logic [7:0]                     hid_joy,
  output logic [5:0]                     joy0,
  output logic [4:0]                     joy1,
  output logic [5:0]                     db9_joy,
  input  logic [`ST_KBD_ROWS-1:0][7:0]   kbd_rows,
  input  logic [`ST_KBD_ROWS-1:0]        kbd_row_sel_n,
  output logic [7:0]                     kbd_cols,
  input  logic [23:1]                    rom_addr,
  output logic [22:0]                    flash_addr,
  input  ram_req_t                       ram_req,
  output logic [22:1]                    ram_addr,
  output logic                           ram_cs,
  input  logic [`ST_SAMPLE_W-1:0]        audio_l_in,
  input  logic [`ST_SAMPLE_W-1:0]        audio_r_in,
  output audio_pair_t                    audio_out,
  input  sd_req_t                        fdc_req,
  input  sd_req_t                        acsi_req,
  output sd_cmd_t                        sd_cmd,
  output logic                           core_run
);

  sys_cfg_t   cfg;
  logic [1:0] scramble;
  logic       sd_ready;
  audio_t     audio_l;
  audio_t     audio_r;

  sys_regs u_sys_regs (
    .clk_32   (clk_32),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .scramble (scramble),
    .sd_ready (sd_ready),
    .core_run (core_run),  // reported back in STAT
    .cfg      (cfg)
  );

  input_map u_input_map (
    .cfg       (cfg),
    .db9_pins  (db9_pins),
    .hid_mouse (hid_mouse),
    .hid_joy   (hid_joy),
    .joy0      (joy0),
    .joy1      (joy1),
    .db9_joy   (db9_joy)
  );

  kbd_matrix u_kbd_matrix (
    .rows      (kbd_rows),
    .row_sel_n (kbd_row_sel_n),
    .cols      (kbd_cols)
  );

  mem_map u_mem_map (
    .clk_32     (clk_32),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .rom_addr   (rom_addr),
    .flash_addr (flash_addr),
    .ram_req    (ram_req),
    .ram_addr   (ram_addr),
    .ram_cs     (ram_cs),
    .scramble   (scramble)
  );

  // one scaler per channel
  audio_volume u_audio_l (
    .clk_32 (clk_32),
    .rst_n  (rst_n),
    .volume (cfg.volume),
    .sample (audio_l_in),
    .out    (audio_l)
  );

  audio_volume u_audio_r (
    .clk_32 (clk_32),
    .rst_n  (rst_n),
    .volume (cfg.volume),
    .sample (audio_r_in),
    .out    (audio_r)
  );

  assign audio_out = '{l: audio_l, r: audio_r};

  boot_ctrl #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_boot_ctrl (
    .clk_32       (clk_32),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .reset_button (reset_button),
    .ram_ready    (ram_ready),
    .flash_ready  (flash_ready),
    .img_size     (img_size),
    .sd_ready     (sd_ready),
    .core_run     (core_run)
  );

  sd_req_arb u_sd_req_arb (
    .clk_32 (clk_32),
    .rst_n  (rst_n),
    .fdc    (fdc_req),
    .acsi   (acsi_req),
    .cmd    (sd_cmd)
  );

endmodule

`default_nettype wire

/* bench/tb_st_glue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "st_defs.svh"

module tb_st_glue import st_pkg::*; ();

  localparam int WAIT_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = 20000;  // tests need about 1.5k cycles, wide margin

  logic                         clk_32;
  logic                         rst_n;
  axil_req_t                    axil_req;
  axil_rsp_t                    axil_rsp;
  logic                         reset_button;
  logic                         ram_ready;
  logic                         flash_ready;
  logic [31:0]                  img_size;
  logic [5:0]                   db9_pins;
  logic [5:0]                   hid_mouse;
  logic [7:0]                   hid_joy;
  logic [5:0]                   joy0;
  logic [4:0]                   joy1;
  logic [5:0]                   db9_joy;
  logic [`ST_KBD_ROWS-1:0][7:0] kbd_rows;
  logic [`ST_KBD_ROWS-1:0]      kbd_row_sel_n;
  logic [7:0]                   kbd_cols;
  logic [23:1]                  rom_addr;
  logic [22:0]                  flash_addr;
  ram_req_t                     ram_req;
  logic [22:1]                  ram_addr;
  logic                         ram_cs;
  logic [`ST_SAMPLE_W-1:0]      audio_l_in;
  logic [`ST_SAMPLE_W-1:0]      audio_r_in;
  audio_pair_t                  audio_out;
  sd_req_t                      fdc_req;
  sd_req_t                      acsi_req;
  sd_cmd_t                      sd_cmd;
  logic                         core_run;

  // expected config, tracked from the bench's own writes
  logic [1:0]  sh_volume;
  port_mouse_e sh_mouse;
  logic        sh_ste;
  logic        sh_tos;
  logic [1:0]  sh_scramble;  // counts cold boot rising edges
  logic [1:0]  sh_ctrl;
  logic        arb_own;      // expected sd owner, 1 = acsi

  integer seed = 32'h609c;
  int     cycles;
  int     n_checks;
  logic   chk_on;           // checker compares outputs while set
  string  test_name;
  logic [`ST_SAMPLE_W-1:0] prev_l;  // samples taken by the audio regs
  logic [`ST_SAMPLE_W-1:0] prev_r;

  st_glue_top #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_st_glue_top (
    .clk_32        (clk_32),
    .rst_n         (rst_n),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .reset_button  (reset_button),
    .ram_ready     (ram_ready),
    .flash_ready   (flash_ready),
    .img_size      (img_size),
    .db9_pins      (db9_pins),
    .hid_mouse     (hid_mouse),
    .hid_joy       (hid_joy),
    .joy0          (joy0),
    .joy1          (joy1),
    .db9_joy       (db9_joy),
    .kbd_rows      (kbd_rows),
    .kbd_row_sel_n (kbd_row_sel_n),
    .kbd_cols      (kbd_cols),
    .rom_addr      (rom_addr),
    .flash_addr    (flash_addr),
    .ram_req       (ram_req),
    .ram_addr      (ram_addr),
    .ram_cs        (ram_cs),
    .audio_l_in    (audio_l_in),
    .audio_r_in    (audio_r_in),
    .audio_out     (audio_out),
    .fdc_req       (fdc_req),
    .acsi_req      (acsi_req),
    .sd_cmd        (sd_cmd),
    .core_run      (core_run)
  );

  initial begin
    clk_32 = 1'b0;
    forever #10 clk_32 = ~clk_32;  // 50 MHz bench clock, period 20 ns
  end

  // 15 bit sample sign extended to 16, then shifted by the volume step
  function automatic logic [15:0] ref_audio(input logic [1:0] vol, input logic [14:0] s);
    case (vol)
      2'd0:    return 16'd0;
      2'd1:    return {{3{s[14]}}, s[14:2]};
      2'd2:    return {{2{s[14]}}, s[14:1]};
      default: return {s[14], s};
    endcase
  endfunction

  function automatic logic [5:0] ref_atari(input logic [5:0] p);
    return ~{p[5], p[0], p[2], p[1], p[4], p[3]};
  endfunction

  function automatic logic [5:0] ref_amiga(input logic [5:0] p);
    return ~{p[5], p[0], p[3], p[1], p[4], p[2]};
  endfunction

  function automatic logic [5:0] ref_joy0(input port_mouse_e m, input logic [5:0] mouse,
                                          input logic [5:0] p);
    case (m)
      HID:       return mouse;
      DB9_ATARI: return ref_atari(p);
      DB9_AMIGA: return ref_amiga(p);
      default:   return 6'd0;
    endcase
  endfunction

  function automatic logic [5:0] ref_db9_joy(input port_mouse_e m, input logic [5:0] p);
    return (m == HID) ? ref_atari(p) : 6'd0;
  endfunction

  // five joystick lines, both sources merged
  function automatic logic [4:0] ref_joy1(input port_mouse_e m, input logic [7:0] joy,
                                          input logic [5:0] p);
    logic [5:0] db9;
    db9 = ref_db9_joy(m, p);
    return joy[4:0] | db9[4:0];
  endfunction

  function automatic logic [7:0] ref_cols(input logic [`ST_KBD_ROWS-1:0][7:0] rows,
                                          input logic [`ST_KBD_ROWS-1:0] sel_n);
    logic [7:0] acc;
    acc = 8'hff;
    for (int i = 0; i < `ST_KBD_ROWS; i++) begin
      if (!sel_n[i])
        acc = acc & rows[i];
    end
    return acc;
  endfunction

  function automatic logic [22:0] ref_flash(input logic tos, input logic ste,
                                            input logic [23:1] a);
    return {4'b0001, tos, ste, a[17:1]};
  endfunction

  function automatic logic [22:1] ref_ram_addr(input logic [23:1] a, input logic [1:0] scr);
    return {a[22:5], a[4:3] ^ scr, a[2:1]};
  endfunction

  function automatic sd_cmd_t ref_sd_cmd(input sd_req_t f, input sd_req_t a, input logic own);
    sd_cmd_t c;
    logic    sel;
    sel       = own || (|a.rd) || (|a.wr);  // acsi now or still owner
    c.rstart  = {a.rd, f.rd};
    c.wstart  = {a.wr, f.wr};
    c.sector  = sel ? a.lba : f.lba;
    c.wr_byte = sel ? a.wr_byte : f.wr_byte;
    return c;
  endfunction

  task automatic stop_on_error();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  // run limit
  always @(posedge clk_32) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, the DUT stopped responding", cycles);
      stop_on_error();
    end
  end

  // compares all mapping outputs between clock edges
  always @(negedge clk_32) begin
    if (chk_on) begin
      check_eq("joy0", ref_joy0(sh_mouse, hid_mouse, db9_pins), joy0);
      check_eq("db9_joy", ref_db9_joy(sh_mouse, db9_pins), db9_joy);
      check_eq("joy1", ref_joy1(sh_mouse, hid_joy, db9_pins), joy1);
      check_eq("kbd_cols", ref_cols(kbd_rows, kbd_row_sel_n), kbd_cols);
      check_eq("flash_addr", ref_flash(sh_tos, sh_ste, rom_addr), flash_addr);
      check_eq("ram_addr", ref_ram_addr(ram_req.addr, sh_scramble), ram_addr);
      check_eq("ram_cs", !ram_req.ras_n && !ram_req.addr[23], ram_cs);
      check_eq("audio_l", ref_audio(sh_volume, prev_l), audio_out.l);  // one cycle late
      check_eq("audio_r", ref_audio(sh_volume, prev_r), audio_out.r);
    end
    prev_l = audio_l_in;
    prev_r = audio_r_in;
  end

  task automatic apply_reset();
    @(posedge clk_32);
    rst_n <= 1'b0;
    repeat (10) @(posedge clk_32);
    rst_n <= 1'b1;
    sh_volume   = 2'd0;  // registers clear on reset
    sh_mouse    = HID;
    sh_ste      = 1'b0;
    sh_tos      = 1'b0;
    sh_scramble = 2'd0;
    sh_ctrl     = 2'd0;
    arb_own     = 1'b0;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_32);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    do @(negedge clk_32); while (!axil_rsp.awready);
    @(posedge clk_32);  // accept edge
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    do @(negedge clk_32); while (!axil_rsp.bvalid);
    check_eq("bresp", 2'b00, axil_rsp.bresp);  // always OKAY
    @(posedge clk_32);
    axil_req.bready <= 1'b1;
    @(posedge clk_32);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk_32);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    do @(negedge clk_32); while (!axil_rsp.arready);
    @(posedge clk_32);
    axil_req.arvalid <= 1'b0;
    do @(negedge clk_32); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    check_eq("rresp", 2'b00, axil_rsp.rresp);
    @(posedge clk_32);
    axil_req.rready <= 1'b1;
    @(posedge clk_32);
    axil_req.rready <= 1'b0;
  endtask

  task automatic set_cfg(input logic [1:0] chipset, input logic [1:0] vol,
                         input logic [1:0] mouse, input logic tos);
    axi_write(`ST_REG_CFG, {23'd0, tos, mouse, vol, 2'b00, chipset});
    sh_volume = vol;
    sh_mouse  = port_mouse_e'(mouse);
    sh_ste    = (chipset == STE);
    sh_tos    = tos;
  endtask

  task automatic set_ctrl(input logic [31:0] data);
    axi_write(`ST_REG_CTRL, data);
    if (data[1] && !sh_ctrl[1])
      sh_scramble = sh_scramble + 2'd1;  // cold boot rising edge
    sh_ctrl = data[1:0];
  endtask

  task automatic drive_random();
    @(posedge clk_32);
    db9_pins      <= $random(seed);
    hid_mouse     <= $random(seed);
    hid_joy       <= $random(seed);
    for (int i = 0; i < `ST_KBD_ROWS; i++)
      kbd_rows[i] <= $random(seed);
    kbd_row_sel_n <= $random(seed);
    rom_addr      <= $random(seed);
    ram_req       <= $random(seed);
    audio_l_in    <= $random(seed);
    audio_r_in    <= $random(seed);
  endtask

  task automatic run_checked(input int n);
    chk_on = 1'b1;
    repeat (n) drive_random();
    repeat (2) @(posedge clk_32);  // last sample still has to pass the audio register
    chk_on = 1'b0;
  endtask

  task automatic arb_step(input logic [1:0] f_rd, input logic [1:0] f_wr,
                          input logic [1:0] a_rd, input logic [1:0] a_wr);
    sd_req_t f;
    sd_req_t a;
    f.rd      = f_rd;
    f.wr      = f_wr;
    f.lba     = $random(seed);
    f.wr_byte = $random(seed);
    a.rd      = a_rd;
    a.wr      = a_wr;
    a.lba     = $random(seed);
    a.wr_byte = $random(seed);
    @(posedge clk_32);
    fdc_req  <= f;
    acsi_req <= a;
    @(negedge clk_32);
    check_eq("sd_cmd", ref_sd_cmd(f, a, arb_own), sd_cmd);
    if ((|a.rd) || (|a.wr))
      arb_own = 1'b1;
    if ((|f.rd) || (|f.wr))
      arb_own = 1'b0;  // floppy wins a tie
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    int          cnt;
    rst_n         = 1'b0;
    axil_req      = '0;
    reset_button  = 1'b0;
    ram_ready     = 1'b1;
    flash_ready   = 1'b1;
    img_size      = 32'd0;  // no image mounted yet
    db9_pins      = 6'h3f;
    hid_mouse     = '0;
    hid_joy       = '0;
    kbd_rows      = '1;
    kbd_row_sel_n = '1;
    rom_addr      = '0;
    ram_req       = '1;
    audio_l_in    = '0;
    audio_r_in    = '0;
    fdc_req       = '0;
    acsi_req      = '0;
    chk_on        = 1'b0;
    cycles        = 0;
    n_checks      = 0;
    apply_reset();

    test_name = "register";
    repeat (4) begin
      r = $random(seed);
      axi_write(`ST_REG_CFG, r);
      axi_read(`ST_REG_CFG, d);
      check_eq("cfg", r & 32'h7ff, d);  // eleven config bits stored
      r = $random(seed);
      set_ctrl(r);
      axi_read(`ST_REG_CTRL, d);
      check_eq("ctrl", r & 32'h3, d);
    end
    set_ctrl(32'd0);
    axi_read(8'h0c, d);
    check_eq("unmapped", 32'd0, d);
    axi_read(`ST_REG_STAT, d);
    check_eq("stat scramble", sh_scramble, d[1:0]);

    test_name = "volume";
    for (int v = 0; v < 4; v++) begin
      set_cfg(ST, v[1:0], HID, 1'b0);
      run_checked(50);
    end

    test_name = "port map";
    for (int m = 0; m < 4; m++) begin
      set_cfg(ST, 2'd3, m[1:0], 1'b0);
      run_checked(30);
    end

    test_name = "keyboard";
    run_checked(100);

    test_name = "memory";
    for (int t = 0; t < 2; t++) begin
      for (int c = 0; c < 3; c++) begin  // ST, MEGA, STE
        set_cfg(c[1:0], 2'd3, HID, t[0]);
        run_checked(10);
      end
    end
    repeat (3) begin
      set_ctrl(32'd2);  // cold boot pulse
      set_ctrl(32'd0);
      axi_read(`ST_REG_STAT, d);
      check_eq("scramble", sh_scramble, d[1:0]);
      run_checked(20);
    end
    @(posedge clk_32);
    ram_req.ras_n    <= 1'b0;
    ram_req.addr[23] <= 1'b1;  // above 8 MB
    @(negedge clk_32);
    check_eq("ram_cs high mem", 1'b0, ram_cs);

    test_name = "boot";
    apply_reset();  // img_size still zero, timer path
    cnt = 0;
    @(negedge clk_32);
    while (!core_run && cnt < WAIT_CYCLES + 10) begin
      cnt++;
      @(negedge clk_32);
    end
    assert (cnt >= WAIT_CYCLES && cnt <= WAIT_CYCLES + 2) else begin
      $display("ERROR: core_run rose %0d cycles after reset, not near %0d", cnt, WAIT_CYCLES);
      stop_on_error();
    end
    img_size <= 32'h000b_4000;  // 720k image mounted
    apply_reset();
    cnt = 0;
    @(negedge clk_32);
    while (!core_run && cnt < 10) begin
      cnt++;
      @(negedge clk_32);
    end
    assert (core_run && cnt <= 2) else begin
      $display("ERROR: sd_ready took %0d cycles with an image mounted", cnt);
      stop_on_error();
    end
    axi_read(`ST_REG_STAT, d);
    check_eq("stat run ready", 2'b11, d[3:2]);
    set_ctrl(32'd1);  // hold reset
    @(negedge clk_32);
    check_eq("hold reset", 1'b0, core_run);
    set_ctrl(32'd0);
    @(negedge clk_32);
    check_eq("release", 1'b1, core_run);
    @(posedge clk_32);
    reset_button <= 1'b1;
    @(negedge clk_32);
    check_eq("reset button", 1'b0, core_run);
    @(posedge clk_32);
    reset_button <= 1'b0;

    test_name = "arbiter";
    arb_step(2'b00, 2'b00, 2'b00, 2'b00);  // nobody owns yet, floppy side
    arb_step(2'b00, 2'b00, 2'b01, 2'b00);  // acsi read
    repeat (4) arb_step(2'b00, 2'b00, 2'b00, 2'b00);
    arb_step(2'b00, 2'b10, 2'b00, 2'b00);  // floppy write on drive 1
    repeat (3) arb_step(2'b00, 2'b00, 2'b00, 2'b00);
    arb_step(2'b01, 2'b00, 2'b00, 2'b01);  // both at once
    arb_step(2'b00, 2'b00, 2'b00, 2'b00);  // floppy took the tie

    if (n_checks > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("ERROR: no output was compared");
      stop_on_error();
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/st_pkg.sv
source/sys_regs.sv
input/input_map.sv
input/kbd_matrix.sv
memory/mem_map.sv
source/audio_volume.sv
source/boot_ctrl.sv
source/sd_req_arb.sv
source/st_glue_top.sv
bench/tb_st_glue.sv
